// File: common/mmio_config.svh
// MMIO subsystem configuration
`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// Bus widths
`define MMIO_AVMM_ADDR_WIDTH 20
`define MMIO_AVMM_DATA_WIDTH 64
`define MMIO_ST_WIDTH        256

// Capacities
`define MMIO_RD_CAP          8
`define MMIO_CSR_COUNT       16

// Request beat fields
`define MMIO_REQ_FMTTYPE     7:0
`define MMIO_REQ_TAG         17:8
`define MMIO_REQ_LENGTH      27:18
`define MMIO_REQ_REQ_ID      43:28
`define MMIO_REQ_ADDR        107:44
`define MMIO_REQ_PAYLOAD     191:128

// Completion beat fields
`define MMIO_CPL_FMTTYPE     7:0
`define MMIO_CPL_TAG         17:8
`define MMIO_CPL_BYTE_COUNT  31:18
`define MMIO_CPL_REQ_ID      47:32
`define MMIO_CPL_LOW_ADDR    54:48
`define MMIO_CPL_RDATA       191:128

`endif

// File: common/mmio_pkg.sv
// MMIO shared types and TLP codes
`include "mmio_config.svh"

package mmio_pkg;

    // --------------------------------------------------------------------------
    // Field types
    // --------------------------------------------------------------------------
    typedef logic [7:0]                            mmio_fmttype_t;
    typedef logic [9:0]                            mmio_tag_t;
    typedef logic [15:0]                           mmio_req_id_t;
    // Length in bytes, as carried in the completion byte count
    typedef logic [13:0]                           mmio_len_t;
    typedef logic [`MMIO_AVMM_ADDR_WIDTH-1:0]      mmio_addr_t;
    typedef logic [`MMIO_AVMM_DATA_WIDTH-1:0]      mmio_data_t;
    typedef logic [`MMIO_AVMM_DATA_WIDTH/8-1:0]    mmio_be_t;
    typedef logic [6:0]                            mmio_low_addr_t;

    // --------------------------------------------------------------------------
    // TLP format and type codes
    // --------------------------------------------------------------------------
    localparam mmio_fmttype_t MEM_READ_32  = 8'h00;
    localparam mmio_fmttype_t MEM_READ_64  = 8'h20;
    localparam mmio_fmttype_t MEM_WRITE_32 = 8'h40;
    localparam mmio_fmttype_t MEM_WRITE_64 = 8'h60;
    // Completion with data
    localparam mmio_fmttype_t CPL_DATA     = 8'h4A;

endpackage

// File: rx_bridge/avst_rx_mmio_bridge.sv
// Avalon-ST request to Avalon-MM bridge
`timescale 1ns/1ps
`include "mmio_config.svh"

module avst_rx_mmio_bridge (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        rx_valid,
    input  logic                        rx_sop,
    input  logic                        rx_eop,
    input  logic [`MMIO_ST_WIDTH-1:0]   rx_data,
    output logic                        rx_ready,

    input  logic                        avmm_waitrequest,
    input  logic                        avmm_writeresponsevalid,
    input  logic                        avmm_readdatavalid,
    output logic                        avmm_write,
    output logic                        avmm_read,
    output mmio_pkg::mmio_addr_t        avmm_address,
    output mmio_pkg::mmio_data_t        avmm_writedata,
    output mmio_pkg::mmio_be_t          avmm_byteenable,

    output logic                        tlp_rd_strb,
    output mmio_pkg::mmio_tag_t         tlp_rd_tag,
    output mmio_pkg::mmio_len_t         tlp_rd_length,
    output mmio_pkg::mmio_req_id_t      tlp_rd_req_id,
    output mmio_pkg::mmio_low_addr_t    tlp_rd_low_addr
);

    import mmio_pkg::*;

    localparam int CNT_W = $clog2(`MMIO_RD_CAP) + 1;
    localparam logic [CNT_W-1:0] RD_CAP   = CNT_W'(`MMIO_RD_CAP);
    // Two reads may still slip in after the decision to stall
    localparam logic [CNT_W-1:0] RD_LIMIT = CNT_W'(`MMIO_RD_CAP - 2);

    typedef enum logic [2:0] {
        ST_RESET,
        ST_READY,
        ST_WAIT_READ,
        ST_WAIT_VALID,
        ST_WAIT_WRITE,
        ST_WAIT_RESP
    } rx_state_t;

    rx_state_t        state;
    rx_state_t        state_next;

    // Registered request beat
    logic             beat_valid;
    mmio_fmttype_t    beat_fmttype;
    mmio_tag_t        beat_tag;
    logic [9:0]       beat_len_dw;
    mmio_req_id_t     beat_req_id;
    logic [63:0]      beat_addr;
    mmio_data_t       beat_payload;

    // Decoded request
    logic             dec_read;
    logic             dec_write;
    logic [63:0]      dec_addr;
    mmio_len_t        dec_length;
    logic [2:0]       dec_offset;
    mmio_data_t       dec_wdata;
    mmio_be_t         dec_be;

    logic [CNT_W-1:0] rd_count;
    logic             rd_issue;

    // Bytes enabled from the offset up to offset plus length
    function automatic mmio_be_t byte_enable(input logic [2:0] offset, input mmio_len_t length);
        mmio_be_t be;
        for (int i = 0; i < $bits(mmio_be_t); i++)
        begin
            be[i] = (i >= offset) && (i < offset + length);
        end
        return be;
    endfunction

    // --------------------------------------------------------------------------
    // Stream sink
    // --------------------------------------------------------------------------
    assign rx_ready = (state == ST_READY);

    // Pending beat is consumed on the next edge the target can take a command
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            beat_valid <= 1'b0;
        else if (rx_valid && rx_ready)
            beat_valid <= rx_sop && rx_eop;
        else if (!avmm_waitrequest)
            beat_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rx_valid && rx_ready)
        begin
            beat_fmttype <= rx_data[`MMIO_REQ_FMTTYPE];
            beat_tag     <= rx_data[`MMIO_REQ_TAG];
            beat_len_dw  <= rx_data[`MMIO_REQ_LENGTH];
            beat_req_id  <= rx_data[`MMIO_REQ_REQ_ID];
            beat_addr    <= rx_data[`MMIO_REQ_ADDR];
            beat_payload <= rx_data[`MMIO_REQ_PAYLOAD];
        end
    end

    // Header decode, unsupported types fall through as no-ops
    always_comb
    begin
        dec_read  = 1'b0;
        dec_write = 1'b0;
        dec_addr  = 64'd0;
        case (beat_fmttype)
            MEM_READ_32:
            begin
                dec_read = beat_valid;
                dec_addr = {32'd0, beat_addr[31:0]};
            end
            MEM_WRITE_32:
            begin
                dec_write = beat_valid;
                dec_addr  = {32'd0, beat_addr[31:0]};
            end
            MEM_READ_64:
            begin
                dec_read = beat_valid;
                dec_addr = beat_addr;
            end
            MEM_WRITE_64:
            begin
                dec_write = beat_valid;
                dec_addr  = beat_addr;
            end
            default:
            begin
                dec_addr = 64'd0;
            end
        endcase
    end

    assign dec_length = {2'b00, beat_len_dw, 2'b00};
    assign dec_offset = dec_addr[2:0];
    assign dec_wdata  = beat_payload << (8 * dec_offset);
    assign dec_be     = byte_enable(dec_offset, dec_length);

    // --------------------------------------------------------------------------
    // Outstanding reads
    // --------------------------------------------------------------------------
    assign rd_issue = avmm_read && !avmm_waitrequest;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_count <= '0;
        else
        begin
            case ({rd_issue, avmm_readdatavalid})
                2'b10:   rd_count <= rd_count + 1'b1;
                2'b01:   rd_count <= rd_count - 1'b1;
                default: rd_count <= rd_count;
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // Ready FSM
    // --------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= ST_RESET;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ST_RESET:
                if (!avmm_waitrequest)
                    state_next = ST_READY;
            ST_READY:
            begin
                if (dec_write)
                    state_next = ST_WAIT_WRITE;
                else if (dec_read && rd_count >= RD_LIMIT)
                    state_next = ST_WAIT_READ;
            end
            ST_WAIT_READ:
                if (rd_issue)
                    state_next = ST_WAIT_VALID;
            ST_WAIT_VALID:
                if (avmm_readdatavalid)
                    state_next = ST_READY;
            ST_WAIT_WRITE:
                if (avmm_write && !avmm_waitrequest)
                    state_next = ST_WAIT_RESP;
            ST_WAIT_RESP:
                if (avmm_writeresponsevalid)
                    state_next = ST_READY;
            default:
                state_next = ST_RESET;
        endcase
    end

    // --------------------------------------------------------------------------
    // Command issue and read sideband
    // --------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            avmm_write <= 1'b0;
            avmm_read  <= 1'b0;
        end
        else if (!avmm_waitrequest)
        begin
            avmm_write <= dec_write;
            avmm_read  <= dec_read;
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat_valid && !avmm_waitrequest)
        begin
            avmm_address    <= dec_addr[`MMIO_AVMM_ADDR_WIDTH-1:0];
            avmm_writedata  <= dec_wdata;
            avmm_byteenable <= dec_be;
            tlp_rd_tag      <= beat_tag;
            tlp_rd_length   <= dec_length;
            tlp_rd_req_id   <= beat_req_id;
        end
    end

    assign tlp_rd_strb     = rd_issue;
    assign tlp_rd_low_addr = avmm_address[6:0];

    // Target must finish clearing before any command leaves
    a_no_cmd_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_RESET) |-> !(avmm_read || avmm_write));

    // Stall margin keeps the TX queue from overflowing
    a_rd_count_cap: assert property (@(posedge clk) disable iff (!rst_n)
        rd_count <= RD_CAP);

endmodule

// File: tx_bridge/avst_tx_cpl_bridge.sv
// Read completion builder
`timescale 1ns/1ps
`include "mmio_config.svh"

module avst_tx_cpl_bridge (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        tlp_rd_strb,
    input  mmio_pkg::mmio_tag_t         tlp_rd_tag,
    input  mmio_pkg::mmio_len_t         tlp_rd_length,
    input  mmio_pkg::mmio_req_id_t      tlp_rd_req_id,
    input  mmio_pkg::mmio_low_addr_t    tlp_rd_low_addr,

    input  logic                        avmm_readdatavalid,
    input  mmio_pkg::mmio_data_t        avmm_readdata,

    output logic                        cpl_valid,
    output logic                        cpl_sop,
    output logic                        cpl_eop,
    output logic [`MMIO_ST_WIDTH-1:0]   cpl_data
);

    import mmio_pkg::*;

    localparam int PTR_W = $clog2(`MMIO_RD_CAP);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`MMIO_RD_CAP - 1);
    localparam logic [CNT_W-1:0] DEPTH    = CNT_W'(`MMIO_RD_CAP);

    // Sideband queue storage
    mmio_tag_t        q_tag      [`MMIO_RD_CAP];
    mmio_len_t        q_length   [`MMIO_RD_CAP];
    mmio_req_id_t     q_req_id   [`MMIO_RD_CAP];
    mmio_low_addr_t   q_low_addr [`MMIO_RD_CAP];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic             q_full;
    logic             q_empty;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign q_full  = (q_count == DEPTH);
    assign q_empty = (q_count == '0);

    // --------------------------------------------------------------------------
    // Sideband queue
    // --------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (tlp_rd_strb)
        begin
            q_tag[wr_ptr]      <= tlp_rd_tag;
            q_length[wr_ptr]   <= tlp_rd_length;
            q_req_id[wr_ptr]   <= tlp_rd_req_id;
            q_low_addr[wr_ptr] <= tlp_rd_low_addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end
        else
        begin
            if (tlp_rd_strb)
                wr_ptr <= next_ptr(wr_ptr);
            if (avmm_readdatavalid)
                rd_ptr <= next_ptr(rd_ptr);
            case ({tlp_rd_strb, avmm_readdatavalid})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // Completion beat
    // --------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cpl_valid <= 1'b0;
        else
            cpl_valid <= avmm_readdatavalid;
    end

    // Head entry pairs with the returning data, since reads return in order
    always_ff @(posedge clk)
    begin
        if (avmm_readdatavalid)
        begin
            cpl_data                       <= '0;
            cpl_data[`MMIO_CPL_FMTTYPE]    <= CPL_DATA;
            cpl_data[`MMIO_CPL_TAG]        <= q_tag[rd_ptr];
            cpl_data[`MMIO_CPL_BYTE_COUNT] <= q_length[rd_ptr];
            cpl_data[`MMIO_CPL_REQ_ID]     <= q_req_id[rd_ptr];
            cpl_data[`MMIO_CPL_LOW_ADDR]   <= q_low_addr[rd_ptr];
            cpl_data[`MMIO_CPL_RDATA]      <= avmm_readdata;
        end
    end

    // Every completion is a single beat
    assign cpl_sop = cpl_valid;
    assign cpl_eop = cpl_valid;

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        avmm_readdatavalid |-> !q_empty);

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        tlp_rd_strb |-> !q_full);

endmodule

// File: logic/mmio_csr_target.sv
// CSR register bank
`timescale 1ns/1ps
`include "mmio_config.svh"

module mmio_csr_target (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    avmm_write,
    input  logic                    avmm_read,
    input  mmio_pkg::mmio_addr_t    avmm_address,
    input  mmio_pkg::mmio_data_t    avmm_writedata,
    input  mmio_pkg::mmio_be_t      avmm_byteenable,

    output logic                    avmm_waitrequest,
    output mmio_pkg::mmio_data_t    avmm_readdata,
    output logic                    avmm_readdatavalid,
    output logic                    avmm_writeresponsevalid
);

    import mmio_pkg::*;

    localparam int IDX_W = $clog2(`MMIO_CSR_COUNT);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`MMIO_CSR_COUNT - 1);

    mmio_data_t       regs [`MMIO_CSR_COUNT];

    logic             clearing;
    logic [IDX_W-1:0] clr_idx;
    logic [IDX_W-1:0] idx;
    logic             wr_take;
    logic             rd_take;

    // Read pipeline stage one
    logic             rd_valid_s1;
    mmio_data_t       rd_data_s1;

    // Registers are 8 bytes apart, upper address bits ignored
    assign idx = avmm_address[IDX_W+2:3];

    assign avmm_waitrequest = clearing;
    assign wr_take          = avmm_write && !clearing;
    assign rd_take          = avmm_read && !clearing;

    // --------------------------------------------------------------------------
    // Clearing phase, one register per cycle
    // --------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            clearing <= 1'b1;
            clr_idx  <= '0;
        end
        else if (clearing)
        begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == LAST_IDX)
                clearing <= 1'b0;
        end
    end

    // Register bank with byte-enabled writes
    always_ff @(posedge clk)
    begin
        if (clearing)
            regs[clr_idx] <= '0;
        else if (wr_take)
        begin
            for (int b = 0; b < $bits(mmio_be_t); b++)
            begin
                if (avmm_byteenable[b])
                    regs[idx][8*b +: 8] <= avmm_writedata[8*b +: 8];
            end
        end
    end

    // --------------------------------------------------------------------------
    // Responses
    // --------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rd_take)
            rd_data_s1 <= regs[idx];
        if (rd_valid_s1)
            avmm_readdata <= rd_data_s1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_valid_s1             <= 1'b0;
            avmm_readdatavalid      <= 1'b0;
            avmm_writeresponsevalid <= 1'b0;
        end
        else
        begin
            rd_valid_s1             <= rd_take;
            avmm_readdatavalid      <= rd_valid_s1;
            avmm_writeresponsevalid <= wr_take;
        end
    end

    // The bridge issues one command per beat
    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(avmm_read && avmm_write));

endmodule

// File: logic/mmio_subsystem_top.sv
// MMIO target subsystem
`timescale 1ns/1ps
`include "mmio_config.svh"

module mmio_subsystem_top (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        rx_valid,
    input  logic                        rx_sop,
    input  logic                        rx_eop,
    input  logic [`MMIO_ST_WIDTH-1:0]   rx_data,
    output logic                        rx_ready,

    output logic                        cpl_valid,
    output logic                        cpl_sop,
    output logic                        cpl_eop,
    output logic [`MMIO_ST_WIDTH-1:0]   cpl_data
);

    import mmio_pkg::*;

    // Memory-mapped bus
    logic           avmm_write;
    logic           avmm_read;
    mmio_addr_t     avmm_address;
    mmio_data_t     avmm_writedata;
    mmio_be_t       avmm_byteenable;
    logic           avmm_waitrequest;
    mmio_data_t     avmm_readdata;
    logic           avmm_readdatavalid;
    logic           avmm_writeresponsevalid;

    // Read sideband
    logic           tlp_rd_strb;
    mmio_tag_t      tlp_rd_tag;
    mmio_len_t      tlp_rd_length;
    mmio_req_id_t   tlp_rd_req_id;
    mmio_low_addr_t tlp_rd_low_addr;

    avst_rx_mmio_bridge rx_bridge0 (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .rx_valid                (rx_valid),
        .rx_sop                  (rx_sop),
        .rx_eop                  (rx_eop),
        .rx_data                 (rx_data),
        .rx_ready                (rx_ready),
        .avmm_waitrequest        (avmm_waitrequest),
        .avmm_writeresponsevalid (avmm_writeresponsevalid),
        .avmm_readdatavalid      (avmm_readdatavalid),
        .avmm_write              (avmm_write),
        .avmm_read               (avmm_read),
        .avmm_address            (avmm_address),
        .avmm_writedata          (avmm_writedata),
        .avmm_byteenable         (avmm_byteenable),
        .tlp_rd_strb             (tlp_rd_strb),
        .tlp_rd_tag              (tlp_rd_tag),
        .tlp_rd_length           (tlp_rd_length),
        .tlp_rd_req_id           (tlp_rd_req_id),
        .tlp_rd_low_addr         (tlp_rd_low_addr)
    );

    mmio_csr_target csr0 (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .avmm_write              (avmm_write),
        .avmm_read               (avmm_read),
        .avmm_address            (avmm_address),
        .avmm_writedata          (avmm_writedata),
        .avmm_byteenable         (avmm_byteenable),
        .avmm_waitrequest        (avmm_waitrequest),
        .avmm_readdata           (avmm_readdata),
        .avmm_readdatavalid      (avmm_readdatavalid),
        .avmm_writeresponsevalid (avmm_writeresponsevalid)
    );

    avst_tx_cpl_bridge tx_bridge0 (
        .clk                (clk),
        .rst_n              (rst_n),
        .tlp_rd_strb        (tlp_rd_strb),
        .tlp_rd_tag         (tlp_rd_tag),
        .tlp_rd_length      (tlp_rd_length),
        .tlp_rd_req_id      (tlp_rd_req_id),
        .tlp_rd_low_addr    (tlp_rd_low_addr),
        .avmm_readdatavalid (avmm_readdatavalid),
        .avmm_readdata      (avmm_readdata),
        .cpl_valid          (cpl_valid),
        .cpl_sop            (cpl_sop),
        .cpl_eop            (cpl_eop),
        .cpl_data           (cpl_data)
    );

endmodule

// File: sim/tb_mmio_subsystem.sv
// MMIO subsystem testbench
`timescale 1ns/1ps
`include "mmio_config.svh"

module tb_mmio_subsystem;

    import mmio_pkg::*;

    localparam int NUM_RANDOM   = 400;
    localparam int NUM_DIRECTED = 32;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 16;
    localparam int CYCLE_LIMIT  = (NUM_RANDOM + NUM_DIRECTED) * 30 + RESET_CYCLES
                                  + `MMIO_CSR_COUNT;

    logic                      clk;
    logic                      rst_n;
    logic                      rx_valid;
    logic                      rx_sop;
    logic                      rx_eop;
    logic [`MMIO_ST_WIDTH-1:0] rx_data;
    logic                      rx_ready;
    logic                      cpl_valid;
    logic                      cpl_sop;
    logic                      cpl_eop;
    logic [`MMIO_ST_WIDTH-1:0] cpl_data;

    // Reference register bank
    mmio_data_t     model_regs [`MMIO_CSR_COUNT];

    // Expected completions, one entry per accepted read
    mmio_tag_t      exp_tag_q[$];
    mmio_req_id_t   exp_req_id_q[$];
    mmio_len_t      exp_count_q[$];
    mmio_low_addr_t exp_low_q[$];
    mmio_data_t     exp_data_q[$];

    int seed;
    int cycles;
    int reads_accepted;
    int cpl_seen;
    int ready_wait;
    int drain_wait;

    mmio_subsystem_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_valid  (rx_valid),
        .rx_sop    (rx_sop),
        .rx_eop    (rx_eop),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .cpl_valid (cpl_valid),
        .cpl_sop   (cpl_sop),
        .cpl_eop   (cpl_eop),
        .cpl_data  (cpl_data)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------
    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic int random_below(input int range);
        return int'($unsigned($random(seed)) % $unsigned(range));
    endfunction

    function automatic mmio_data_t random_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic idle_cycles(input int count);
        repeat (count)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // Drives one beat, holds it until taken, then updates the model
    task automatic send_request(input mmio_fmttype_t code, input int idx, input int len_dw,
                                input int offset, input mmio_data_t payload);
        mmio_tag_t                 tag;
        mmio_req_id_t              req_id;
        logic [63:0]               addr;
        logic [`MMIO_ST_WIDTH-1:0] beat;
        tag       = mmio_tag_t'(random_below(1024));
        req_id    = mmio_req_id_t'(random_below(65536));
        // Upper address bits are random and must not matter
        addr      = {$random(seed), $random(seed)};
        addr[6:0] = 7'(idx * 8 + offset);
        beat                    = '0;
        beat[`MMIO_REQ_FMTTYPE] = code;
        beat[`MMIO_REQ_TAG]     = tag;
        beat[`MMIO_REQ_LENGTH]  = 10'(len_dw);
        beat[`MMIO_REQ_REQ_ID]  = req_id;
        beat[`MMIO_REQ_ADDR]    = addr;
        beat[`MMIO_REQ_PAYLOAD] = payload;
        rx_valid = 1'b1;
        rx_sop   = 1'b1;
        rx_eop   = 1'b1;
        rx_data  = beat;
        @(negedge clk);
        while (!rx_ready)
            @(negedge clk);
        // Transfer edge
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
        rx_sop   = 1'b0;
        rx_eop   = 1'b0;
        if (code == MEM_WRITE_32 || code == MEM_WRITE_64)
        begin
            // Payload starts at the address byte offset
            for (int b = 0; b < 8; b++)
            begin
                if (b >= offset && b < offset + 4 * len_dw)
                    model_regs[idx][8*b +: 8] = payload[8*(b-offset) +: 8];
            end
        end
        else if (code == MEM_READ_32 || code == MEM_READ_64)
        begin
            exp_tag_q.push_back(tag);
            exp_req_id_q.push_back(req_id);
            exp_count_q.push_back(mmio_len_t'(4 * len_dw));
            exp_low_q.push_back(addr[6:0]);
            exp_data_q.push_back(model_regs[idx]);
            reads_accepted++;
        end
    endtask

    task automatic send_random_request();
        int            kind;
        int            len_dw;
        int            offset;
        mmio_fmttype_t code;
        kind   = random_below(20);
        len_dw = 1 + random_below(2);
        offset = (len_dw == 1) ? 4 * random_below(2) : 0;
        if (kind < 5)
            code = MEM_READ_32;
        else if (kind < 10)
            code = MEM_READ_64;
        else if (kind < 14)
            code = MEM_WRITE_32;
        else if (kind < 18)
            code = MEM_WRITE_64;
        else
        begin
            code = mmio_fmttype_t'(random_below(256));
            if (code == MEM_READ_32 || code == MEM_READ_64 ||
                code == MEM_WRITE_32 || code == MEM_WRITE_64)
                code = 8'h04;
        end
        send_request(code, random_below(`MMIO_CSR_COUNT), len_dw, offset, random_word());
        idle_cycles(random_below(4));
    endtask

    // -------------------------------------------------------------------------
    // Completion checker
    // -------------------------------------------------------------------------
    always @(negedge clk)
    begin
        if (rst_n && cpl_valid)
        begin
            if (exp_data_q.size() == 0)
            begin
                $display("A completion arrived with no read pending");
                stop_on_failure();
            end
            else
            begin
                cpl_seen++;
                check_value("cpl_sop", 64'(cpl_sop), 64'd1);
                check_value("cpl_eop", 64'(cpl_eop), 64'd1);
                check_value("cpl_fmttype", 64'(cpl_data[`MMIO_CPL_FMTTYPE]), 64'(CPL_DATA));
                check_value("cpl_tag", 64'(cpl_data[`MMIO_CPL_TAG]),
                            64'(exp_tag_q.pop_front()));
                check_value("cpl_byte_count", 64'(cpl_data[`MMIO_CPL_BYTE_COUNT]),
                            64'(exp_count_q.pop_front()));
                check_value("cpl_req_id", 64'(cpl_data[`MMIO_CPL_REQ_ID]),
                            64'(exp_req_id_q.pop_front()));
                check_value("cpl_low_addr", 64'(cpl_data[`MMIO_CPL_LOW_ADDR]),
                            64'(exp_low_q.pop_front()));
                check_value("cpl_rdata", cpl_data[`MMIO_CPL_RDATA], exp_data_q.pop_front());
            end
        end
    end

    // Run limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, %0d completions still pending",
                     cycles, exp_data_q.size());
            stop_on_failure();
        end
    end

    // -------------------------------------------------------------------------
    // Stimulus
    // -------------------------------------------------------------------------
    initial
    begin
        seed           = 32'hc3881cde;
        cycles         = 0;
        reads_accepted = 0;
        cpl_seen       = 0;
        ready_wait     = 0;
        drain_wait     = 0;
        rst_n          = 1'b0;
        rx_valid       = 1'b0;
        rx_sop         = 1'b0;
        rx_eop         = 1'b0;
        rx_data        = '0;
        for (int i = 0; i < `MMIO_CSR_COUNT; i++)
            model_regs[i] = '0;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("rx_ready", 64'(rx_ready), 64'd0);
        check_value("cpl_valid", 64'(cpl_valid), 64'd0);
        @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Sink stays closed while the registers clear
        repeat (`MMIO_CSR_COUNT)
        begin
            @(negedge clk);
            check_value("rx_ready", 64'(rx_ready), 64'd0);
        end
        while (!rx_ready && ready_wait < 4)
        begin
            @(negedge clk);
            ready_wait++;
        end
        if (!rx_ready)
        begin
            $display("rx_ready did not rise after the clearing phase");
            stop_on_failure();
        end
        @(posedge clk);
        #1;

        // Back-to-back reads of the cleared bank
        for (int i = 0; i < `MMIO_CSR_COUNT; i++)
            send_request(MEM_READ_64, i, 2, 0, '0);

        // Both address forms reach the same register
        send_request(MEM_WRITE_64, 5, 2, 0, random_word());
        send_request(MEM_READ_32, 5, 2, 0, '0);
        send_request(MEM_WRITE_32, 9, 2, 0, random_word());
        send_request(MEM_READ_64, 9, 1, 4, '0);

        // Dword writes merge into the upper or lower half
        send_request(MEM_WRITE_64, 3, 2, 0, random_word());
        send_request(MEM_WRITE_32, 3, 1, 4, random_word());
        send_request(MEM_READ_32, 3, 1, 0, '0);
        send_request(MEM_WRITE_64, 3, 1, 0, random_word());
        send_request(MEM_READ_64, 3, 2, 0, '0);

        // Unsupported type is consumed and dropped
        send_request(8'h04, 3, 2, 0, random_word());
        send_request(MEM_READ_32, 3, 2, 0, '0);

        repeat (NUM_RANDOM)
            send_random_request();

        // Last completions trail the last read by a few cycles
        while (exp_data_q.size() != 0 && drain_wait < DRAIN_CYCLES)
        begin
            @(posedge clk);
            drain_wait++;
        end
        repeat (10) @(posedge clk);

        if (exp_data_q.size() != 0)
        begin
            $display("Only %0d of %0d read completions arrived", cpl_seen, reads_accepted);
            stop_on_failure();
        end
        else
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+common
common/mmio_pkg.sv
rx_bridge/avst_rx_mmio_bridge.sv
tx_bridge/avst_tx_cpl_bridge.sv
logic/mmio_csr_target.sv
logic/mmio_subsystem_top.sv
sim/tb_mmio_subsystem.sv

// File: Makefile
# Verilator build and run for the MMIO subsystem

TOP := tb_mmio_subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
